// ==== common/rf_top_consts.svh ====
// Widths, depth and reset values shared by the register files and the key logic.
// The reset key and nonce are fixed placeholders and must be replaced per product.
`ifndef RF_TOP_CONSTS_SVH
`define RF_TOP_CONSTS_SVH

// Register file geometry
`define RF_DATA_W   32
`define RF_ADDR_W   5
`define RF_NUM_REGS 32

// bfloat16 sits in one half of a register word
`define BF16_W 16

// Scrambling key and nonce
`define SCR_KEY_W   128
`define SCR_NONCE_W 64

// Values held until the first key delivery
`define SCR_KEY_RST   128'h3d4a_91c0_7be2_58f6_0a17_c4d9_e25b_86f3
`define SCR_NONCE_RST 64'hf1c2_7a09_5e3b_d846

`endif

// ==== common/rf_top_pkg.sv ====
// Register word types for the integer and bfloat16 register files.
// A floating-point word is seen either as raw bits or as two bfloat16 halves.
`default_nettype none

`include "rf_top_consts.svh"

package rf_top_pkg;

  // One register word
  typedef logic [`RF_DATA_W-1:0] rf_word_t;

  // One bfloat16 value
  typedef logic [`BF16_W-1:0] bf16_t;

  // Upper and lower bfloat16 halves of a word
  typedef struct packed {
    bf16_t hi;
    bf16_t lo;
  } fp_halves_t;

  // Floating-point register word, two decodings
  typedef union packed {
    rf_word_t   raw;
    fp_halves_t half;
  } fp_word_u;

endpackage

`default_nettype wire

// ==== regfile/int_register_file.sv ====
// Flip-flop integer register file, two combinational read ports, one write port.
// Register 0 has no storage and always reads zero; writes to it are dropped.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module int_register_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`RF_ADDR_W-1:0]    raddr_a_i,
  input  logic [`RF_ADDR_W-1:0]    raddr_b_i,
  input  logic [`RF_ADDR_W-1:0]    waddr_i,
  input  logic                     we_i,
  input  rf_top_pkg::rf_word_t     wdata_i,
  output rf_top_pkg::rf_word_t     rdata_a_o,
  output rf_top_pkg::rf_word_t     rdata_b_o
);

  rf_top_pkg::rf_word_t       mem_q [`RF_NUM_REGS];
  logic [`RF_NUM_REGS-1:1]    we_dec;

  // Hard-wired zero
  assign mem_q[0]  = '0;

  for (genvar i = 1; i < `RF_NUM_REGS; i++) begin : gen_regs
    assign we_dec[i] = we_i & (waddr_i == `RF_ADDR_W'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mem_q[i] <= '0;
      end else if (we_dec[i]) begin
        mem_q[i] <= wdata_i;
      end
    end
  end

  // Asynchronous reads
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== regfile/fp_register_file.sv ====
// bfloat16 register file, two combinational read ports, one write port.
// All entries are writable, entry 0 included; reset clears every word.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module fp_register_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`RF_ADDR_W-1:0]    raddr_a_i,
  input  logic [`RF_ADDR_W-1:0]    raddr_b_i,
  input  logic [`RF_ADDR_W-1:0]    waddr_i,
  input  logic                     we_i,
  input  rf_top_pkg::fp_word_u     wdata_i,
  output rf_top_pkg::fp_word_u     rdata_a_o,
  output rf_top_pkg::fp_word_u     rdata_b_o
);

  rf_top_pkg::fp_word_u mem_q [`RF_NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== regfile/rf_port_steer.sv ====
// Steers one write port and two read ports between the integer and FP files.
// The shift moves a bfloat16 between the low half of the bus and the upper half
// of the FP word, in both directions. It has no effect on integer words.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module rf_port_steer (
  input  logic                     we_i,
  input  rf_top_pkg::rf_word_t     wdata_i,
  input  logic                     fp_wdata_sel_i,
  input  logic                     fp_rdata_a_sel_i,
  input  logic                     fp_rdata_b_sel_i,
  input  logic                     fp_shift_i,
  input  rf_top_pkg::rf_word_t     int_rdata_a_i,
  input  rf_top_pkg::rf_word_t     int_rdata_b_i,
  input  rf_top_pkg::fp_word_u     fp_rdata_a_i,
  input  rf_top_pkg::fp_word_u     fp_rdata_b_i,
  output logic                     int_we_o,
  output logic                     fp_we_o,
  output rf_top_pkg::fp_word_u     fp_wdata_o,
  output rf_top_pkg::rf_word_t     rdata_a_o,
  output rf_top_pkg::rf_word_t     rdata_b_o
);

  // Per-port read select, with the upper half brought down when shifting
  function automatic rf_top_pkg::rf_word_t read_word(
    input logic                 fp_sel,
    input logic                 shift,
    input rf_top_pkg::rf_word_t int_word,
    input rf_top_pkg::fp_word_u fp_word
  );
    rf_top_pkg::rf_word_t fp_view;
    fp_view = shift ? {{`BF16_W{1'b0}}, fp_word.half.hi} : fp_word.raw;
    return fp_sel ? fp_view : int_word;
  endfunction

  assign int_we_o = we_i & ~fp_wdata_sel_i;
  assign fp_we_o  = we_i & fp_wdata_sel_i;

  always_comb begin
    fp_wdata_o = '0;
    if (fp_shift_i) begin
      fp_wdata_o.half.hi = wdata_i[`BF16_W-1:0];
      fp_wdata_o.half.lo = '0;
    end else begin
      fp_wdata_o.raw = wdata_i;
    end
  end

  assign rdata_a_o = read_word(fp_rdata_a_sel_i, fp_shift_i, int_rdata_a_i, fp_rdata_a_i);
  assign rdata_b_o = read_word(fp_rdata_b_sel_i, fp_shift_i, int_rdata_b_i, fp_rdata_b_i);

endmodule

`default_nettype wire

// ==== hdl/scramble_key_ctrl.sv ====
// Scrambling key request and hold. The invalidate input is a single-cycle strobe
// and is ignored while a request is open. Key and nonce load on every cycle with
// key_valid_i high, requested or not.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module scramble_key_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     icache_inval_i,
  input  logic                     key_valid_i,
  input  logic [`SCR_KEY_W-1:0]    key_i,
  input  logic [`SCR_NONCE_W-1:0]  nonce_i,
  output logic                     req_o,
  output logic                     key_valid_o,
  output logic [`SCR_KEY_W-1:0]    key_o,
  output logic [`SCR_NONCE_W-1:0]  nonce_o
);

  logic                     req_d, req_q;
  logic                     key_valid_d, key_valid_q;
  logic [`SCR_KEY_W-1:0]    key_q;
  logic [`SCR_NONCE_W-1:0]  nonce_q;

  // Request opens on invalidate, closes when a key arrives
  assign req_d       = req_q ? ~key_valid_i : icache_inval_i;
  // Valid drops with the request, returns with the key
  assign key_valid_d = req_q          ? key_valid_i :
                       icache_inval_i ? 1'b0        :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= `SCR_KEY_RST;
      nonce_q <= `SCR_NONCE_RST;
    end else if (key_valid_i) begin
      key_q   <= key_i;
      nonce_q <= nonce_i;
    end
  end

  assign req_o       = req_q;
  assign key_valid_o = key_valid_q;
  assign key_o       = key_q;
  assign nonce_o     = nonce_q;

endmodule

`default_nettype wire

// ==== hdl/rf_top.sv ====
// Register-file top: integer and bfloat16 files, port steering, sleep status and
// scrambling key logic. Everything runs on clk_i; core_sleep_o is status only.
// Busy is seen one cycle late, the wake-up requests act combinationally.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module rf_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     core_busy_i,
  input  logic                     debug_req_i,
  input  logic                     irq_pending_i,
  input  logic                     irq_nm_i,
  output logic                     core_sleep_o,

  input  logic [`RF_ADDR_W-1:0]    rf_raddr_a_i,
  input  logic [`RF_ADDR_W-1:0]    rf_raddr_b_i,
  input  logic [`RF_ADDR_W-1:0]    rf_waddr_i,
  input  logic                     rf_we_i,
  input  rf_top_pkg::rf_word_t     rf_wdata_i,
  input  logic                     rf_fp_wdata_sel_i,
  input  logic                     rf_fp_rdata_a_sel_i,
  input  logic                     rf_fp_rdata_b_sel_i,
  input  logic                     rf_fp_shift_i,
  output rf_top_pkg::rf_word_t     rf_rdata_a_o,
  output rf_top_pkg::rf_word_t     rf_rdata_b_o,

  input  logic                     icache_inval_i,
  input  logic                     scramble_key_valid_i,
  input  logic [`SCR_KEY_W-1:0]    scramble_key_i,
  input  logic [`SCR_NONCE_W-1:0]  scramble_nonce_i,
  output logic                     scramble_req_o,
  output logic                     scramble_key_valid_o,
  output logic [`SCR_KEY_W-1:0]    scramble_key_o,
  output logic [`SCR_NONCE_W-1:0]  scramble_nonce_o
);

  logic                   core_busy_q;
  logic                   int_we;
  logic                   fp_we;
  rf_top_pkg::fp_word_u   fp_wdata;
  rf_top_pkg::rf_word_t   int_rdata_a, int_rdata_b;
  rf_top_pkg::fp_word_u   fp_rdata_a, fp_rdata_b;

  ////////////////////////////////////////
  // Sleep status
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  assign core_sleep_o = ~(core_busy_q | debug_req_i | irq_pending_i | irq_nm_i);

  ////////////////////////////////////////
  // Register files
  ////////////////////////////////////////

  rf_port_steer u_rf_port_steer (
    .we_i             (rf_we_i),
    .wdata_i          (rf_wdata_i),
    .fp_wdata_sel_i   (rf_fp_wdata_sel_i),
    .fp_rdata_a_sel_i (rf_fp_rdata_a_sel_i),
    .fp_rdata_b_sel_i (rf_fp_rdata_b_sel_i),
    .fp_shift_i       (rf_fp_shift_i),
    .int_rdata_a_i    (int_rdata_a),
    .int_rdata_b_i    (int_rdata_b),
    .fp_rdata_a_i     (fp_rdata_a),
    .fp_rdata_b_i     (fp_rdata_b),
    .int_we_o         (int_we),
    .fp_we_o          (fp_we),
    .fp_wdata_o       (fp_wdata),
    .rdata_a_o        (rf_rdata_a_o),
    .rdata_b_o        (rf_rdata_b_o)
  );

  int_register_file u_int_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .waddr_i   (rf_waddr_i),
    .we_i      (int_we),
    .wdata_i   (rf_wdata_i),
    .rdata_a_o (int_rdata_a),
    .rdata_b_o (int_rdata_b)
  );

  fp_register_file u_fp_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .waddr_i   (rf_waddr_i),
    .we_i      (fp_we),
    .wdata_i   (fp_wdata),
    .rdata_a_o (fp_rdata_a),
    .rdata_b_o (fp_rdata_b)
  );

  ////////////////////////////////////////
  // Scrambling key
  ////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_inval_i (icache_inval_i),
    .key_valid_i    (scramble_key_valid_i),
    .key_i          (scramble_key_i),
    .nonce_i        (scramble_nonce_i),
    .req_o          (scramble_req_o),
    .key_valid_o    (scramble_key_valid_o),
    .key_o          (scramble_key_o),
    .nonce_o        (scramble_nonce_o)
  );

endmodule

`default_nettype wire

// ==== testbench/rf_top_properties.sv ====
// Concurrent checks on rf_top ports, bound into every rf_top instance.
// Checked only outside reset; assert_failed stays set after the first failure.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module rf_top_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_i,
  input logic                  key_valid_i,
  input logic                  irq_nm_i,
  input logic                  sleep_i,
  input logic [`RF_ADDR_W-1:0] raddr_a_i,
  input logic [`RF_ADDR_W-1:0] raddr_b_i,
  input logic                  fp_sel_a_i,
  input logic                  fp_sel_b_i,
  input logic [`RF_DATA_W-1:0] rdata_a_i,
  input logic [`RF_DATA_W-1:0] rdata_b_i
);

  logic assert_failed = 1'b0;

  a_req_valid_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_i && key_valid_i))
    else begin
      $error("scramble request and key valid both high");
      assert_failed = 1'b1;
    end

  // Integer register 0 on either port
  a_int_reg0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_a_i != '0 || fp_sel_a_i || rdata_a_i == '0) &&
    (raddr_b_i != '0 || fp_sel_b_i || rdata_b_i == '0))
    else begin
      $error("integer register 0 read as nonzero");
      assert_failed = 1'b1;
    end

  a_nmi_wakes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_nm_i |-> !sleep_i)
    else begin
      $error("core_sleep_o high with irq_nm_i high");
      assert_failed = 1'b1;
    end

endmodule

bind rf_top rf_top_properties u_rf_top_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (scramble_req_o),
  .key_valid_i (scramble_key_valid_o),
  .irq_nm_i    (irq_nm_i),
  .sleep_i     (core_sleep_o),
  .raddr_a_i   (rf_raddr_a_i),
  .raddr_b_i   (rf_raddr_b_i),
  .fp_sel_a_i  (rf_fp_rdata_a_sel_i),
  .fp_sel_b_i  (rf_fp_rdata_b_sel_i),
  .rdata_a_i   (rf_rdata_a_o),
  .rdata_b_i   (rf_rdata_b_o)
);

`default_nettype wire

// ==== testbench/tb_rf_top.sv ====
// Directed tests for rf_top covering both register files, the half-word shift,
// sleep and the key exchange. Inputs change 1 ns after the rising edge, outputs
// are sampled on the falling edge.
`timescale 1ns/1ps
`default_nettype none

`include "rf_top_consts.svh"

module tb_rf_top;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     core_busy_i, debug_req_i, irq_pending_i, irq_nm_i;
  logic                     core_sleep_o;
  logic [`RF_ADDR_W-1:0]    rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  logic                     rf_we_i;
  logic [`RF_DATA_W-1:0]    rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic                     rf_fp_wdata_sel_i, rf_fp_rdata_a_sel_i;
  logic                     rf_fp_rdata_b_sel_i, rf_fp_shift_i;
  logic                     icache_inval_i, scramble_key_valid_i;
  logic                     scramble_req_o, scramble_key_valid_o;
  logic [`SCR_KEY_W-1:0]    scramble_key_i, scramble_key_o;
  logic [`SCR_NONCE_W-1:0]  scramble_nonce_i, scramble_nonce_o;

  // Expected register contents
  logic [`RF_DATA_W-1:0]    int_model [`RF_NUM_REGS];
  logic [`RF_DATA_W-1:0]    fp_model [`RF_NUM_REGS];
  integer                   seed;
  int                       cycle_cnt;

  rf_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_word(input int idx, input logic [`RF_DATA_W-1:0] data,
                            input logic fp_sel, input logic shift);
    next_cycle();
    rf_we_i           = 1'b1;
    rf_waddr_i        = `RF_ADDR_W'(idx);
    rf_wdata_i        = data;
    rf_fp_wdata_sel_i = fp_sel;
    rf_fp_shift_i     = shift;
  endtask

  task automatic write_stop();
    next_cycle();
    rf_we_i = 1'b0;
  endtask

  task automatic read_check(input int idx_a, input int idx_b, input logic a_sel,
                            input logic b_sel, input logic shift,
                            input logic [`RF_DATA_W-1:0] exp_a,
                            input logic [`RF_DATA_W-1:0] exp_b);
    next_cycle();
    rf_raddr_a_i        = `RF_ADDR_W'(idx_a);
    rf_raddr_b_i        = `RF_ADDR_W'(idx_b);
    rf_fp_rdata_a_sel_i = a_sel;
    rf_fp_rdata_b_sel_i = b_sel;
    rf_fp_shift_i       = shift;
    @(negedge clk_i);
    check("rf_rdata_a_o", 128'(rf_rdata_a_o), 128'(exp_a));
    check("rf_rdata_b_o", 128'(rf_rdata_b_o), 128'(exp_b));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_int_file();
    logic [`RF_DATA_W-1:0] data;
    int                    j;
    int_model[0] = '0;
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      data         = $random(seed);
      int_model[i] = data;
      write_word(i, data, 1'b0, 1'b0);
    end
    // Dropped by the hard-wired zero
    write_word(0, $random(seed), 1'b0, 1'b0);
    write_stop();
    // Port b reads the mirrored address
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      j = `RF_NUM_REGS - 1 - i;
      read_check(i, j, 1'b0, 1'b0, 1'b0, int_model[i], int_model[j]);
    end
  endtask

  task automatic test_fp_plain();
    logic [`RF_DATA_W-1:0] data;
    int                    j;
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      data        = $random(seed);
      fp_model[i] = data;
      write_word(i, data, 1'b1, 1'b0);
    end
    write_stop();
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      j = `RF_NUM_REGS - 1 - i;
      read_check(i, j, 1'b1, 1'b0, 1'b0, fp_model[i], int_model[j]);
      read_check(i, j, 1'b0, 1'b1, 1'b0, int_model[i], fp_model[j]);
    end
  endtask

  task automatic test_fp_shift();
    logic [`RF_DATA_W-1:0] data;
    logic [`RF_DATA_W-1:0] low_half [`RF_NUM_REGS];
    int                    j;
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      data        = $random(seed);
      fp_model[i] = {data[`BF16_W-1:0], {`BF16_W{1'b0}}};
      low_half[i] = {{`BF16_W{1'b0}}, data[`BF16_W-1:0]};
      write_word(i, data, 1'b1, 1'b1);
    end
    write_stop();
    // The integer port keeps the shift on
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      j = `RF_NUM_REGS - 1 - i;
      read_check(i, j, 1'b1, 1'b0, 1'b1, low_half[i], int_model[j]);
      read_check(i, j, 1'b0, 1'b1, 1'b1, int_model[i], low_half[j]);
      read_check(i, j, 1'b1, 1'b1, 1'b0, fp_model[i], fp_model[j]);
    end
  endtask

  task automatic test_sleep();
    @(negedge clk_i);
    check("core_sleep_o", 128'(core_sleep_o), 128'(1'b1));
    for (int k = 0; k < 3; k++) begin
      next_cycle();
      debug_req_i   = (k == 0);
      irq_pending_i = (k == 1);
      irq_nm_i      = (k == 2);
      @(negedge clk_i);
      check("core_sleep_o", 128'(core_sleep_o), 128'(1'b0));
    end
    next_cycle();
    irq_nm_i    = 1'b0;
    core_busy_i = 1'b1;
    // Busy is registered, so sleep holds for one more cycle
    @(negedge clk_i);
    check("core_sleep_o", 128'(core_sleep_o), 128'(1'b1));
    next_cycle();
    core_busy_i = 1'b0;
    @(negedge clk_i);
    check("core_sleep_o", 128'(core_sleep_o), 128'(1'b0));
    next_cycle();
    @(negedge clk_i);
    check("core_sleep_o", 128'(core_sleep_o), 128'(1'b1));
  endtask

  task automatic test_key_exchange();
    logic [`SCR_KEY_W-1:0]   key;
    logic [`SCR_NONCE_W-1:0] nonce;
    key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    nonce = {$random(seed), $random(seed)};
    @(negedge clk_i);
    check("scramble_key_o", scramble_key_o, `SCR_KEY_RST);
    check("scramble_nonce_o", 128'(scramble_nonce_o), 128'(`SCR_NONCE_RST));
    check("scramble_key_valid_o", 128'(scramble_key_valid_o), 128'(1'b1));
    check("scramble_req_o", 128'(scramble_req_o), 128'(1'b0));
    // Second strobe lands while the request is open
    repeat (2) begin
      next_cycle();
      icache_inval_i = 1'b1;
      next_cycle();
      icache_inval_i = 1'b0;
      @(negedge clk_i);
      check("scramble_req_o", 128'(scramble_req_o), 128'(1'b1));
      check("scramble_key_valid_o", 128'(scramble_key_valid_o), 128'(1'b0));
      check("scramble_key_o", scramble_key_o, `SCR_KEY_RST);
    end
    next_cycle();
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = key;
    scramble_nonce_i     = nonce;
    @(negedge clk_i);
    check("scramble_req_o", 128'(scramble_req_o), 128'(1'b1));
    next_cycle();
    scramble_key_valid_i = 1'b0;
    @(negedge clk_i);
    check("scramble_req_o", 128'(scramble_req_o), 128'(1'b0));
    check("scramble_key_valid_o", 128'(scramble_key_valid_o), 128'(1'b1));
    check("scramble_key_o", scramble_key_o, key);
    check("scramble_nonce_o", 128'(scramble_nonce_o), 128'(nonce));
  endtask

  initial begin
    seed                 = 32'hb01a_cf3b;
    rst_ni               = 1'b0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    rf_raddr_a_i         = '0;
    rf_raddr_b_i         = '0;
    rf_waddr_i           = '0;
    rf_we_i              = 1'b0;
    rf_wdata_i           = '0;
    rf_fp_wdata_sel_i    = 1'b0;
    rf_fp_rdata_a_sel_i  = 1'b0;
    rf_fp_rdata_b_sel_i  = 1'b0;
    rf_fp_shift_i        = 1'b0;
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_sleep();
    test_key_exchange();
    test_int_file();
    test_fp_plain();
    test_fp_shift();
    if (!u_dut.u_rf_top_properties.assert_failed) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Assertion failures seen during the run");
      $display("Done: errors found");
      $fatal(1, "failures seen");
    end
  end

endmodule

`default_nettype wire

// ==== rf_top.f ====
+incdir+common
common/rf_top_pkg.sv
regfile/int_register_file.sv
regfile/fp_register_file.sv
regfile/rf_port_steer.sv
hdl/scramble_key_ctrl.sv
hdl/rf_top.sv
testbench/rf_top_properties.sv
testbench/tb_rf_top.sv

// ==== Makefile ====
# Verilator simulation of rf_top; pass is decided by the pass message in the log

VERILATOR ?= verilator
TOP       ?= tb_rf_top
FILELIST  ?= rf_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
